/* rtl/idu_pkg.sv */
`default_nettype none

package idu_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] inst_t;
    typedef logic [4:0]      reg_idx_t;

    // Major opcodes, inst[6:0]
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;

    localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
    localparam logic [6:0] FUNCT7_ALT  = 7'b0100000; // sub, sra, srai

    // funct3 for OP_REG and OP_IMM
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101; // srl/sra by funct7
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;
    localparam logic [2:0] F3_JALR = 3'b000;

    // Access width, shared by loads and stores
    localparam logic [2:0] F3_BYTE   = 3'b000;
    localparam logic [2:0] F3_HALF   = 3'b001;
    localparam logic [2:0] F3_WORD   = 3'b010;
    localparam logic [2:0] F3_BYTE_U = 3'b100;
    localparam logic [2:0] F3_HALF_U = 3'b101;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    typedef enum logic [4:0] {
        ALU_ADD  = 5'd0,  ALU_BEQ  = 5'd1,  ALU_SLTU = 5'd2,  ALU_BNE  = 5'd3,
        ALU_SUB  = 5'd4,  ALU_OR   = 5'd5,  ALU_XOR  = 5'd6,  ALU_BGE  = 5'd7,
        ALU_SLLI = 5'd8,  ALU_AND  = 5'd9,  ALU_SRLI = 5'd10, ALU_SLT  = 5'd11,
        ALU_BLT  = 5'd12, ALU_BLTU = 5'd13, ALU_BGEU = 5'd14, ALU_SLL  = 5'd15,
        ALU_SRAI = 5'd16, ALU_SRA  = 5'd17, ALU_SRL  = 5'd18, ALU_NONE = 5'd31
    } alu_op_e;

    typedef enum logic [1:0] {
        SRC_A_RS1 = 2'd0, SRC_A_PC = 2'd1, SRC_A_ZERO = 2'd3
    } src_a_e;

    typedef enum logic [1:0] {
        SRC_B_IMM = 2'd0, SRC_B_RS2 = 2'd1, SRC_B_FOUR = 2'd2, SRC_B_NONE = 2'd3
    } src_b_e;

    typedef enum logic [2:0] {
        PC_JALR = 3'd1, PC_JAL = 3'd2, PC_BRANCH = 3'd4, PC_SEQ = 3'd6
    } pc_sel_e;

    typedef enum logic [2:0] {
        IMM_I = 3'd0, IMM_U = 3'd1, IMM_J = 3'd2, IMM_S = 3'd3, IMM_B = 3'd4
    } imm_fmt_e;

    typedef enum logic [3:0] {
        LSU_LB  = 4'd0, LSU_LH  = 4'd1, LSU_LW = 4'd2, LSU_LBU = 4'd3, LSU_LHU = 4'd4,
        LSU_SB  = 4'd5, LSU_SH  = 4'd6, LSU_SW = 4'd7, LSU_NONE = 4'd8
    } lsu_op_e;

    typedef struct packed {
        alu_op_e         alu_op;
        src_a_e          src_a;
        src_b_e          src_b;
        pc_sel_e         pc_sel;
        lsu_op_e         lsu_op;
        logic            rd_wen;
        logic            is_load;
        logic            is_store;
        logic [2:0]      mem_bytes; // Store width in bytes
        reg_idx_t        rd;
        reg_idx_t        rs1;
        reg_idx_t        rs2;
        logic [XLEN-1:0] imm;
    } decode_t;

endpackage

`default_nettype wire

/* rtl/idu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module idu_top (
    input  logic             clk,
    input  logic             rst,
    input  logic             inst_valid,
    output logic             inst_ready,
    input  idu_pkg::inst_t   inst,
    output logic             dec_valid,
    input  logic             dec_ready,
    output idu_pkg::decode_t dec
);
    import idu_pkg::*;

    logic            fetch_valid;
    logic            fetch_ready; // Backpressure from the decode register
    inst_t           fetch_inst;
    imm_fmt_e        imm_fmt;
    logic [XLEN-1:0] imm;
    decode_t         dec_next;

    pipe_stage #(.payload_t(inst_t)) u_fetch_q (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (inst_valid),
        .in_ready  (inst_ready),
        .in_data   (inst),
        .out_valid (fetch_valid),
        .out_ready (fetch_ready),
        .out_data  (fetch_inst)
    );

    inst_decoder u_inst_decoder (
        .clk     (clk),
        .inst    (fetch_inst),
        .imm     (imm),
        .imm_fmt (imm_fmt),
        .dec     (dec_next)
    );

    imm_gen u_imm_gen (
        .inst    (fetch_inst),
        .imm_fmt (imm_fmt),
        .imm     (imm)
    );

    pipe_stage #(.payload_t(decode_t)) u_dec_q (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (fetch_valid),
        .in_ready  (fetch_ready),
        .in_data   (dec_next),
        .out_valid (dec_valid),
        .out_ready (dec_ready),
        .out_data  (dec)
    );

endmodule

`default_nettype wire

/* rtl/imm_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module imm_gen (
    input  idu_pkg::inst_t           inst,
    input  idu_pkg::imm_fmt_e        imm_fmt,
    output logic [idu_pkg::XLEN-1:0] imm
);
    import idu_pkg::*;

    logic sign;

    assign sign = inst[31]; // Every format takes its sign from bit 31

    always_comb begin
        case (imm_fmt)
            IMM_I: begin
                imm = {{(XLEN-12){sign}}, inst[31:20]};
            end
            IMM_U: begin
                imm = {inst[31:12], 12'b0};
            end
            IMM_J: begin
                // imm[20|10:1|11|19:12]
                imm = {{(XLEN-20){sign}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            IMM_S: begin
                imm = {{(XLEN-12){sign}}, inst[31:25], inst[11:7]};
            end
            IMM_B: begin
                // imm[12|10:5] in funct7, imm[4:1|11] in rd
                imm = {{(XLEN-12){sign}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* rtl/inst_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
    input  logic                    clk,
    input  idu_pkg::inst_t          inst,
    input  logic [idu_pkg::XLEN-1:0] imm,
    output idu_pkg::imm_fmt_e       imm_fmt,
    output idu_pkg::decode_t        dec
);
    import idu_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    decode_t    ctl;     // Everything except the immediate

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    always_comb begin
        ctl           = '0;
        ctl.alu_op    = ALU_NONE;
        ctl.src_a     = SRC_A_RS1;
        ctl.src_b     = SRC_B_NONE;
        ctl.pc_sel    = PC_SEQ;
        ctl.lsu_op    = LSU_NONE;
        ctl.mem_bytes = 3'd1;
        imm_fmt       = IMM_I;
        case (opcode)
            OP_REG: begin
                if (funct7 == FUNCT7_BASE ||
                    (funct7 == FUNCT7_ALT && (funct3 == F3_ADD || funct3 == F3_SR))) begin
                    case (funct3)
                        F3_ADD:  ctl.alu_op = (funct7 == FUNCT7_ALT) ? ALU_SUB : ALU_ADD;
                        F3_SLL:  ctl.alu_op = ALU_SLL;
                        F3_SLT:  ctl.alu_op = ALU_SLT;
                        F3_SLTU: ctl.alu_op = ALU_SLTU;
                        F3_XOR:  ctl.alu_op = ALU_XOR;
                        F3_SR:   ctl.alu_op = (funct7 == FUNCT7_ALT) ? ALU_SRA : ALU_SRL;
                        F3_OR:   ctl.alu_op = ALU_OR;
                        default: ctl.alu_op = ALU_AND;
                    endcase
                    ctl.src_b  = SRC_B_RS2;
                    ctl.rd_wen = 1'b1;
                end
            end
            OP_IMM: begin
                case (funct3)
                    F3_ADD:  ctl.alu_op = ALU_ADD;
                    F3_SLT:  ctl.alu_op = ALU_SLT;
                    F3_SLTU: ctl.alu_op = ALU_SLTU;
                    F3_XOR:  ctl.alu_op = ALU_XOR;
                    F3_OR:   ctl.alu_op = ALU_OR;
                    F3_AND:  ctl.alu_op = ALU_AND;
                    F3_SLL:  if (funct7 == FUNCT7_BASE) ctl.alu_op = ALU_SLLI;
                    default: begin // F3_SR, shamt type in funct7
                        if (funct7 == FUNCT7_BASE) ctl.alu_op = ALU_SRLI;
                        if (funct7 == FUNCT7_ALT)  ctl.alu_op = ALU_SRAI;
                    end
                endcase
                ctl.rd_wen = (ctl.alu_op != ALU_NONE);
                ctl.src_b  = ctl.rd_wen ? SRC_B_IMM : SRC_B_NONE;
            end
            OP_LOAD: begin
                case (funct3)
                    F3_BYTE:   ctl.lsu_op = LSU_LB;
                    F3_HALF:   ctl.lsu_op = LSU_LH;
                    F3_WORD:   ctl.lsu_op = LSU_LW;
                    F3_BYTE_U: ctl.lsu_op = LSU_LBU;
                    F3_HALF_U: ctl.lsu_op = LSU_LHU;
                    default:   ctl.lsu_op = LSU_NONE;
                endcase
                if (ctl.lsu_op != LSU_NONE) begin
                    ctl.alu_op  = ALU_ADD;   // Address = rs1 + imm
                    ctl.src_b   = SRC_B_IMM;
                    ctl.is_load = 1'b1;
                    ctl.rd_wen  = 1'b1;
                end
            end
            OP_STORE: begin
                case (funct3)
                    F3_BYTE: ctl.lsu_op = LSU_SB;
                    F3_HALF: ctl.lsu_op = LSU_SH;
                    F3_WORD: ctl.lsu_op = LSU_SW;
                    default: ctl.lsu_op = LSU_NONE;
                endcase
                if (ctl.lsu_op != LSU_NONE) begin
                    ctl.alu_op    = ALU_ADD;
                    ctl.src_b     = SRC_B_IMM;
                    ctl.is_store  = 1'b1;
                    ctl.mem_bytes = (funct3 == F3_WORD) ? 3'd4 :
                                    (funct3 == F3_HALF) ? 3'd2 : 3'd1;
                    imm_fmt       = IMM_S;
                end
            end
            OP_BRANCH: begin
                case (funct3)
                    F3_BEQ:  ctl.alu_op = ALU_BEQ;
                    F3_BNE:  ctl.alu_op = ALU_BNE;
                    F3_BLT:  ctl.alu_op = ALU_BLT;
                    F3_BGE:  ctl.alu_op = ALU_BGE;
                    F3_BLTU: ctl.alu_op = ALU_BLTU;
                    F3_BGEU: ctl.alu_op = ALU_BGEU;
                    default: ctl.alu_op = ALU_NONE;
                endcase
                if (ctl.alu_op != ALU_NONE) begin
                    ctl.src_b  = SRC_B_RS2;
                    ctl.pc_sel = PC_BRANCH;
                    imm_fmt    = IMM_B;
                end
            end
            OP_JAL: begin
                ctl.alu_op = ALU_ADD; // Link value pc + 4
                ctl.src_a  = SRC_A_PC;
                ctl.src_b  = SRC_B_FOUR;
                ctl.pc_sel = PC_JAL;
                ctl.rd_wen = 1'b1;
                imm_fmt    = IMM_J;
            end
            OP_JALR: begin
                if (funct3 == F3_JALR) begin
                    ctl.alu_op = ALU_ADD;
                    ctl.src_a  = SRC_A_PC;
                    ctl.src_b  = SRC_B_FOUR;
                    ctl.pc_sel = PC_JALR;
                    ctl.rd_wen = 1'b1;
                end
            end
            OP_LUI, OP_AUIPC: begin
                ctl.alu_op = ALU_ADD;
                ctl.src_a  = (opcode == OP_LUI) ? SRC_A_ZERO : SRC_A_PC;
                ctl.src_b  = SRC_B_IMM;
                ctl.rd_wen = 1'b1;
                imm_fmt    = IMM_U;
            end
            default: ; // Unknown opcode keeps the defaults
        endcase
    end

    // Immediate comes back from imm_gen, merged here with the fixed fields
    always_comb begin
        dec     = ctl;
        dec.rd  = inst[11:7];
        dec.rs1 = inst[19:15];
        dec.rs2 = inst[24:20];
        dec.imm = imm;
    end

    default clocking cb @(posedge clk);
    endclocking

    a_ld_st_excl: assert property (!(dec.is_load && dec.is_store))
        else $error("inst_decoder: load and store both set");

endmodule

`default_nettype wire

/* rtl/pipe_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module pipe_stage #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    // Accept when empty or when the held item leaves this cycle
    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_data <= in_data; // Payload only moves on a transfer
        end
    end

    // Stalled output must hold until taken
    property p_hold_on_stall;
        @(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data);
    endproperty

    a_hold_on_stall: assert property (p_hold_on_stall)
        else $error("pipe_stage: output changed while stalled");

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_idu -f tb.f -o tb_idu_sim

./obj_dir/tb_idu_sim | tee sim.log

if grep -q "Done: errors found" sim.log; then
    echo "Simulation failed, see sim.log"
    exit 1
fi
echo "Simulation passed"

/* sim/idu_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module idu_checker (
    input  logic             clk,
    input  logic             rst,
    input  logic             inst_ready,
    input  logic             dec_valid,
    input  logic             dec_ready,
    input  idu_pkg::decode_t dec
);
    import idu_pkg::*;

    string   name_q[$];
    decode_t exp_q[$];
    int      pass_count = 0;
    int      error_count = 0;
    logic    rst_q = 1'b1;

    task automatic push_expected(input string name, input decode_t expected);
        name_q.push_back(name);
        exp_q.push_back(expected);
    endtask

    function automatic int outstanding();
        return exp_q.size();
    endfunction

    function automatic int errors();
        return error_count;
    endfunction

    always @(posedge clk) begin : watch
        decode_t expected;
        string   name;
        rst_q <= rst;
        // First edge out of reset, nothing pushed yet
        if (rst_q && !rst) begin
            if (dec_valid || !inst_ready) begin
                $display("ERROR: after reset dec_valid=%b inst_ready=%b, expected 0 and 1",
                         dec_valid, inst_ready);
                error_count++;
            end else begin
                $display("PASS reset_state");
                pass_count++;
            end
        end
        if (!rst && dec_valid && dec_ready) begin
            if (exp_q.size() == 0) begin
                $display("ERROR: decode output %h came out with no instruction outstanding",
                         dec);
                error_count++;
            end else begin
                expected = exp_q.pop_front();
                name     = name_q.pop_front();
                if (dec !== expected) begin
                    $display("MISMATCH %0s expected %h actual %h", name, expected, dec);
                    error_count++;
                end else begin
                    $display("PASS %0s", name);
                    pass_count++;
                end
            end
        end
    end

    task automatic final_report();
        foreach (name_q[i]) begin
            $display("ERROR: %0s was accepted but never came out", name_q[i]);
            error_count++;
        end
        $display("Summary: %0d passed, %0d failed", pass_count, error_count);
    endtask

endmodule

`default_nettype wire

/* sim/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk; // 100 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

/* sim/tb_idu.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_idu;
    import idu_pkg::*;

    localparam int RESET_CYCLES = 8;

    logic        clk;
    logic        rst;
    logic        inst_valid;
    logic        inst_ready;
    inst_t       inst;
    logic        dec_valid;
    logic        dec_ready;
    decode_t     dec;
    string       name_tab[$];
    inst_t       inst_tab[$];
    decode_t     exp_tab[$];
    logic        table_ready;
    logic [31:0] lfsr_state;

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        logic fb;
        fb = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], fb};
    endfunction

    // Flags are {rd_wen, is_load, is_store}
    task automatic add_test(input string name, input inst_t word, input alu_op_e alu,
                            input src_a_e sa, input src_b_e sb, input pc_sel_e pc,
                            input lsu_op_e lsu, input logic [2:0] flags,
                            input logic [2:0] bytes, input logic [XLEN-1:0] imm,
                            input reg_idx_t rd, input reg_idx_t rs1, input reg_idx_t rs2);
        decode_t expected;
        expected.alu_op    = alu;
        expected.src_a     = sa;
        expected.src_b     = sb;
        expected.pc_sel    = pc;
        expected.lsu_op    = lsu;
        expected.rd_wen    = flags[2];
        expected.is_load   = flags[1];
        expected.is_store  = flags[0];
        expected.mem_bytes = bytes;
        expected.rd        = rd;
        expected.rs1       = rs1;
        expected.rs2       = rs2;
        expected.imm       = imm;
        name_tab.push_back(name);
        inst_tab.push_back(word);
        exp_tab.push_back(expected);
    endtask

    task automatic build_table();
        // R-type on x1 = x2 op x3
        add_test("add", 32'h0031_00b3, ALU_ADD, SRC_A_RS1, SRC_B_RS2, PC_SEQ,
                 LSU_NONE, 3'b100, 3'd1, 32'h0000_0003, 5'd1, 5'd2, 5'd3);
        add_test("sub", 32'h4031_00b3, ALU_SUB, SRC_A_RS1, SRC_B_RS2, PC_SEQ,
                 LSU_NONE, 3'b100, 3'd1, 32'h0000_0403, 5'd1, 5'd2, 5'd3);
        add_test("sll", 32'h0031_10b3, ALU_SLL, SRC_A_RS1, SRC_B_RS2, PC_SEQ,
                 LSU_NONE, 3'b100, 3'd1, 32'h0000_0003, 5'd1, 5'd2, 5'd3);
        add_test("slt", 32'h0031_20b3, ALU_SLT, SRC_A_RS1, SRC_B_RS2, PC_SEQ,
                 LSU_NONE, 3'b100, 3'd1, 32'h0000_0003, 5'd1, 5'd2, 5'd3);
        add_test("sltu", 32'h0031_30b3, ALU_SLTU, SRC_A_RS1, SRC_B_RS2, PC_SEQ,
                 LSU_NONE, 3'b100, 3'd1, 32'h0000_0003, 5'd1, 5'd2, 5'd3);
        add_test("xor", 32'h0031_40b3, ALU_XOR, SRC_A_RS1, SRC_B_RS2, PC_SEQ,
                 LSU_NONE, 3'b100, 3'd1, 32'h0000_0003, 5'd1, 5'd2, 5'd3);
        add_test("or", 32'h0031_60b3, ALU_OR, SRC_A_RS1, SRC_B_RS2, PC_SEQ,
                 LSU_NONE, 3'b100, 3'd1, 32'h0000_0003, 5'd1, 5'd2, 5'd3);
        add_test("srl", 32'h0031_50b3, ALU_SRL, SRC_A_RS1, SRC_B_RS2, PC_SEQ,
                 LSU_NONE, 3'b100, 3'd1, 32'h0000_0003, 5'd1, 5'd2, 5'd3);
        add_test("sra", 32'h4031_50b3, ALU_SRA, SRC_A_RS1, SRC_B_RS2, PC_SEQ,
                 LSU_NONE, 3'b100, 3'd1, 32'h0000_0403, 5'd1, 5'd2, 5'd3);
        add_test("and", 32'h0031_70b3, ALU_AND, SRC_A_RS1, SRC_B_RS2, PC_SEQ,
                 LSU_NONE, 3'b100, 3'd1, 32'h0000_0003, 5'd1, 5'd2, 5'd3);
        add_test("addi", 32'hff01_0093, ALU_ADD, SRC_A_RS1, SRC_B_IMM, PC_SEQ,
                 LSU_NONE, 3'b100, 3'd1, 32'hffff_fff0, 5'd1, 5'd2, 5'd16);
        add_test("sltiu", 32'h0051_3093, ALU_SLTU, SRC_A_RS1, SRC_B_IMM, PC_SEQ,
                 LSU_NONE, 3'b100, 3'd1, 32'h0000_0005, 5'd1, 5'd2, 5'd5);
        add_test("ori", 32'hfff1_6093, ALU_OR, SRC_A_RS1, SRC_B_IMM, PC_SEQ,
                 LSU_NONE, 3'b100, 3'd1, 32'hffff_ffff, 5'd1, 5'd2, 5'd31);
        add_test("slli", 32'h0031_1093, ALU_SLLI, SRC_A_RS1, SRC_B_IMM, PC_SEQ,
                 LSU_NONE, 3'b100, 3'd1, 32'h0000_0003, 5'd1, 5'd2, 5'd3);
        add_test("srli", 32'h0031_5093, ALU_SRLI, SRC_A_RS1, SRC_B_IMM, PC_SEQ,
                 LSU_NONE, 3'b100, 3'd1, 32'h0000_0003, 5'd1, 5'd2, 5'd3);
        add_test("srai", 32'h4031_5093, ALU_SRAI, SRC_A_RS1, SRC_B_IMM, PC_SEQ,
                 LSU_NONE, 3'b100, 3'd1, 32'h0000_0403, 5'd1, 5'd2, 5'd3);
        // Loads with offset -4 except lw
        add_test("lb", 32'hffc1_0083, ALU_ADD, SRC_A_RS1, SRC_B_IMM, PC_SEQ,
                 LSU_LB, 3'b110, 3'd1, 32'hffff_fffc, 5'd1, 5'd2, 5'd28);
        add_test("lh", 32'hffc1_1083, ALU_ADD, SRC_A_RS1, SRC_B_IMM, PC_SEQ,
                 LSU_LH, 3'b110, 3'd1, 32'hffff_fffc, 5'd1, 5'd2, 5'd28);
        add_test("lw", 32'h0081_2083, ALU_ADD, SRC_A_RS1, SRC_B_IMM, PC_SEQ,
                 LSU_LW, 3'b110, 3'd1, 32'h0000_0008, 5'd1, 5'd2, 5'd8);
        add_test("lbu", 32'hffc1_4083, ALU_ADD, SRC_A_RS1, SRC_B_IMM, PC_SEQ,
                 LSU_LBU, 3'b110, 3'd1, 32'hffff_fffc, 5'd1, 5'd2, 5'd28);
        add_test("lhu", 32'hffc1_5083, ALU_ADD, SRC_A_RS1, SRC_B_IMM, PC_SEQ,
                 LSU_LHU, 3'b110, 3'd1, 32'hffff_fffc, 5'd1, 5'd2, 5'd28);
        add_test("sb", 32'hfe31_0c23, ALU_ADD, SRC_A_RS1, SRC_B_IMM, PC_SEQ,
                 LSU_SB, 3'b001, 3'd1, 32'hffff_fff8, 5'd24, 5'd2, 5'd3);
        add_test("sh", 32'hfe31_1c23, ALU_ADD, SRC_A_RS1, SRC_B_IMM, PC_SEQ,
                 LSU_SH, 3'b001, 3'd2, 32'hffff_fff8, 5'd24, 5'd2, 5'd3);
        add_test("sw", 32'h0031_2623, ALU_ADD, SRC_A_RS1, SRC_B_IMM, PC_SEQ,
                 LSU_SW, 3'b001, 3'd4, 32'h0000_000c, 5'd12, 5'd2, 5'd3);
        // Branch offsets -8, +16 and +2048
        add_test("beq", 32'hfe31_0ce3, ALU_BEQ, SRC_A_RS1, SRC_B_RS2, PC_BRANCH,
                 LSU_NONE, 3'b000, 3'd1, 32'hffff_fff8, 5'd25, 5'd2, 5'd3);
        add_test("bne", 32'h0031_1863, ALU_BNE, SRC_A_RS1, SRC_B_RS2, PC_BRANCH,
                 LSU_NONE, 3'b000, 3'd1, 32'h0000_0010, 5'd16, 5'd2, 5'd3);
        add_test("blt", 32'hfe31_4ce3, ALU_BLT, SRC_A_RS1, SRC_B_RS2, PC_BRANCH,
                 LSU_NONE, 3'b000, 3'd1, 32'hffff_fff8, 5'd25, 5'd2, 5'd3);
        add_test("bge", 32'hfe31_5ce3, ALU_BGE, SRC_A_RS1, SRC_B_RS2, PC_BRANCH,
                 LSU_NONE, 3'b000, 3'd1, 32'hffff_fff8, 5'd25, 5'd2, 5'd3);
        add_test("bltu", 32'h0031_6863, ALU_BLTU, SRC_A_RS1, SRC_B_RS2, PC_BRANCH,
                 LSU_NONE, 3'b000, 3'd1, 32'h0000_0010, 5'd16, 5'd2, 5'd3);
        add_test("bgeu", 32'h0031_70e3, ALU_BGEU, SRC_A_RS1, SRC_B_RS2, PC_BRANCH,
                 LSU_NONE, 3'b000, 3'd1, 32'h0000_0800, 5'd1, 5'd2, 5'd3);
        add_test("jal", 32'hffdf_f0ef, ALU_ADD, SRC_A_PC, SRC_B_FOUR, PC_JAL,
                 LSU_NONE, 3'b100, 3'd1, 32'hffff_fffc, 5'd1, 5'd31, 5'd29);
        add_test("jalr", 32'hffc1_00e7, ALU_ADD, SRC_A_PC, SRC_B_FOUR, PC_JALR,
                 LSU_NONE, 3'b100, 3'd1, 32'hffff_fffc, 5'd1, 5'd2, 5'd28);
        add_test("lui", 32'habcd_e0b7, ALU_ADD, SRC_A_ZERO, SRC_B_IMM, PC_SEQ,
                 LSU_NONE, 3'b100, 3'd1, 32'habcd_e000, 5'd1, 5'd27, 5'd28);
        add_test("auipc", 32'h1234_5097, ALU_ADD, SRC_A_PC, SRC_B_IMM, PC_SEQ,
                 LSU_NONE, 3'b100, 3'd1, 32'h1234_5000, 5'd1, 5'd8, 5'd3);
        // Unknown opcode and a load with a reserved width
        add_test("bad_opcode", 32'h0000_007f, ALU_NONE, SRC_A_RS1, SRC_B_NONE, PC_SEQ,
                 LSU_NONE, 3'b000, 3'd1, 32'h0000_0000, 5'd0, 5'd0, 5'd0);
        add_test("bad_load", 32'h0001_6003, ALU_NONE, SRC_A_RS1, SRC_B_NONE, PC_SEQ,
                 LSU_NONE, 3'b000, 3'd1, 32'h0000_0000, 5'd0, 5'd2, 5'd0);
    endtask

    tb_clock #(.RESET_CYCLES(RESET_CYCLES)) u_tb_clock (
        .clk (clk),
        .rst (rst)
    );

    idu_top u_idu_top (
        .clk        (clk),
        .rst        (rst),
        .inst_valid (inst_valid),
        .inst_ready (inst_ready),
        .inst       (inst),
        .dec_valid  (dec_valid),
        .dec_ready  (dec_ready),
        .dec        (dec)
    );

    idu_checker u_checker (
        .clk        (clk),
        .rst        (rst),
        .inst_ready (inst_ready),
        .dec_valid  (dec_valid),
        .dec_ready  (dec_ready),
        .dec        (dec)
    );

    // Random downstream stall from one LFSR bit per cycle
    initial begin : back_pressure
        lfsr_state = 32'h19b6_8bfd;
        dec_ready <= 1'b0;
        forever begin
            @(posedge clk);
            lfsr_state = lfsr_step(lfsr_state);
            dec_ready <= lfsr_state[0];
        end
    end

    initial begin : drive
        int idx;
        table_ready = 1'b0;
        inst_valid <= 1'b0;
        inst       <= '0;
        build_table();
        table_ready = 1'b1;
        @(posedge clk);
        while (rst) @(posedge clk);
        for (idx = 0; idx < name_tab.size(); idx++) begin
            inst_valid <= 1'b1;
            inst       <= inst_tab[idx];
            @(posedge clk);
            while (!inst_ready) @(posedge clk); // Hold the word until taken
            u_checker.push_expected(name_tab[idx], exp_tab[idx]);
        end
        inst_valid <= 1'b0;
        while (u_checker.outstanding() != 0) @(posedge clk);
        repeat (4) @(posedge clk); // Catch any extra output
        u_checker.final_report();
        if (u_checker.errors() == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin : watchdog
        int limit_cycles;
        wait (table_ready);
        limit_cycles = name_tab.size() * 20 + RESET_CYCLES;
        repeat (limit_cycles) @(posedge clk);
        $display("ERROR: run did not finish within %0d cycles", limit_cycles);
        u_checker.final_report();
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
rtl/idu_pkg.sv
rtl/pipe_stage.sv
rtl/inst_decoder.sv
rtl/imm_gen.sv
rtl/idu_top.sv
sim/tb_clock.sv
sim/idu_checker.sv
sim/tb_idu.sv
